//--- all.f
common/tile_pkg.sv
design/endpoint/net_in_fifo.sv
design/endpoint/out_credit_counter.sv
design/endpoint/pkt_encode.sv
design/mem/banked_xbar_mem.sv
design/freeze_ctrl.sv
design/reserve_tracker.sv
design/tile_proc.sv
test/tb_clock_gen.sv
test/tb_tile_proc.sv

//--- common/tile_pkg.sv
package tile_pkg;

   // datapath widths
   localparam int unsigned DATA_W = 32;
   localparam int unsigned MASK_W = DATA_W / 8;
   localparam int unsigned CORD_W = 2;

   // word address as carried in a network packet
   localparam int unsigned NET_ADDR_W = 12;

   // scratchpad geometry
   localparam int unsigned BANK_WORDS  = 256;
   localparam int unsigned NUM_BANKS   = 2;
   localparam int unsigned MEM_ADDR_W  = 9;
   localparam int unsigned BANK_ADDR_W = $clog2(BANK_WORDS);

   // crossbar ports: 0 dmem, 1 network, 2 imem (also the priority order)
   localparam int unsigned XBAR_PORTS = 3;
   localparam int unsigned PORT_SEL_W = $clog2(XBAR_PORTS);

   // input queue depth, also the credits the network starts with
   localparam int unsigned IN_FIFO_ELS = 4;
   localparam int unsigned FIFO_PTR_W  = $clog2(IN_FIFO_ELS);

   // outgoing credit limit and counter width
   localparam int unsigned MAX_OUT_CREDITS = 4;
   localparam int unsigned CREDIT_W        = 3;

   // core byte address map
   localparam int unsigned REMOTE_BIT    = 31;
   localparam int unsigned REMOTE_X_LSB  = 22;
   localparam int unsigned REMOTE_Y_LSB  = 20;
   localparam int unsigned ADDR_WORD_LSB = 2;

   // store writes memory, freeze carries the freeze flag in data bit 0
   typedef enum logic
   {
      OP_STORE  = 1'b0,
      OP_FREEZE = 1'b1
   } net_op_e;

   typedef struct packed
   {
      net_op_e                 op;
      logic [CORD_W-1:0]       x_cord;
      logic [CORD_W-1:0]       y_cord;
      logic [CORD_W-1:0]       src_x;
      logic [CORD_W-1:0]       src_y;
      logic [NET_ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]       data;
      logic [MASK_W-1:0]       mask;
   } net_pkt_t;

   // core memory request, addr is a byte address
   typedef struct packed
   {
      logic                    v;
      logic                    we;
      logic                    reserve;
      logic [31:0]             addr;
      logic [DATA_W-1:0]       wdata;
      logic [MASK_W-1:0]       mask;
   } mem_req_t;

   typedef struct packed
   {
      logic                    v;
      logic [DATA_W-1:0]       data;
   } mem_rsp_t;

endpackage

//--- design/endpoint/net_in_fifo.sv
module net_in_fifo import tile_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  logic     v_i,
   input  net_pkt_t pkt_i,
   output logic     v_o,
   output net_pkt_t pkt_o,
   input  logic     yumi_i,
   output logic     credit_o
);

   // packet storage, written at the tail and read at the head
   net_pkt_t                mem_r [IN_FIFO_ELS];
   logic [FIFO_PTR_W-1:0]   rd_ptr_r;
   logic [FIFO_PTR_W-1:0]   wr_ptr_r;
   // occupancy never exceeds the network's credits
   logic [CREDIT_W-1:0]     count_r;

   assign v_o   = (count_r != '0);
   assign pkt_o = mem_r[rd_ptr_r];

   // no full check, the sender only writes while holding a credit
   always_ff @(posedge clk_i)
   begin
      if (v_i)
         mem_r[wr_ptr_r] <= pkt_i;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         count_r  <= '0;
         credit_o <= 1'b0;
      end
      else
      begin
         if (v_i)
            wr_ptr_r <= wr_ptr_r + FIFO_PTR_W'(1);
         if (yumi_i)
            rd_ptr_r <= rd_ptr_r + FIFO_PTR_W'(1);
         // push and pop together leave the count alone
         if (v_i && !yumi_i)
            count_r <= count_r + CREDIT_W'(1);
         else if (!v_i && yumi_i)
            count_r <= count_r - CREDIT_W'(1);
         // each freed slot goes back to the network one cycle later
         credit_o <= yumi_i;
      end
   end

endmodule

//--- design/endpoint/out_credit_counter.sv
module out_credit_counter import tile_pkg::*;
(
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic send_i,
   input  logic credit_return_i,
   output logic has_credit_o,
   output logic outstanding_o
);

   // credits still available for outgoing packets
   logic [CREDIT_W-1:0] count_r;

   assign has_credit_o  = (count_r != '0);
   // any missing credit means a packet is still unacknowledged
   assign outstanding_o = (count_r != CREDIT_W'(MAX_OUT_CREDITS));

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         count_r <= CREDIT_W'(MAX_OUT_CREDITS);
      end
      else
      begin
         // send and return in one cycle cancel out
         case ({send_i, credit_return_i})
            2'b10:   count_r <= count_r - CREDIT_W'(1);
            2'b01:   count_r <= count_r + CREDIT_W'(1);
            default: count_r <= count_r;
         endcase
      end
   end

endmodule

//--- design/endpoint/pkt_encode.sv
module pkt_encode import tile_pkg::*;
(
   input  mem_req_t          req_i,
   input  logic [CORD_W-1:0] my_x_i,
   input  logic [CORD_W-1:0] my_y_i,
   output logic              v_o,
   output net_pkt_t          pkt_o
);

   logic remote;

   // remote bit set means the request leaves the tile
   assign remote = req_i.addr[REMOTE_BIT];

   // only remote writes become packets, remote reads are not supported
   assign v_o = req_i.v & remote & req_i.we;

   always_comb
   begin
      pkt_o.op     = OP_STORE;
      // target tile comes from the upper address bits
      pkt_o.x_cord = req_i.addr[REMOTE_X_LSB +: CORD_W];
      pkt_o.y_cord = req_i.addr[REMOTE_Y_LSB +: CORD_W];
      // sender is this tile
      pkt_o.src_x  = my_x_i;
      pkt_o.src_y  = my_y_i;
      // drop the byte offset, keep the word address
      pkt_o.addr   = req_i.addr[ADDR_WORD_LSB +: NET_ADDR_W];
      pkt_o.data   = req_i.wdata;
      pkt_o.mask   = req_i.mask;
   end

endmodule

//--- design/freeze_ctrl.sv
module freeze_ctrl import tile_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  logic     net_v_i,
   input  net_pkt_t net_pkt_i,
   output logic     pop_o,
   output logic     freeze_o
);

   typedef enum logic
   {
      FROZEN  = 1'b0,
      RUNNING = 1'b1
   } state_e;

   state_e state_r;
   state_e state_nxt;

   // control packets never wait, they leave the queue head at once
   assign pop_o = net_v_i & (net_pkt_i.op == OP_FREEZE);

   // data bit 0 picks the new state
   always_comb
   begin
      state_nxt = state_r;
      if (pop_o)
      begin
         if (net_pkt_i.data[0])
            state_nxt = FROZEN;
         else
            state_nxt = RUNNING;
      end
   end

   // tile comes out of reset frozen
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         state_r <= FROZEN;
      else
         state_r <= state_nxt;
   end

   assign freeze_o = (state_r == FROZEN);

endmodule

//--- design/mem/banked_xbar_mem.sv
module banked_xbar_mem import tile_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  logic     freeze_i,
   input  mem_req_t dreq_i,
   input  mem_req_t ireq_i,
   input  logic     net_v_i,
   input  net_pkt_t net_pkt_i,
   output logic     dyumi_o,
   output logic     iyumi_o,
   output logic     net_yumi_o,
   output mem_rsp_t drsp_o,
   output mem_rsp_t irsp_o
);

   // local word addresses, bit 0 picks the bank
   logic [MEM_ADDR_W-1:0] d_word;
   logic [MEM_ADDR_W-1:0] i_word;
   logic [MEM_ADDR_W-1:0] n_word;

   // per port request fields, index is also the priority
   logic [XBAR_PORTS-1:0]                   port_v;
   logic [XBAR_PORTS-1:0]                   port_we;
   logic [XBAR_PORTS-1:0]                   port_bank;
   logic [XBAR_PORTS-1:0][BANK_ADDR_W-1:0]  port_row;
   logic [XBAR_PORTS-1:0][DATA_W-1:0]       port_wdata;
   logic [XBAR_PORTS-1:0][MASK_W-1:0]       port_mask;
   logic [XBAR_PORTS-1:0]                   port_yumi;

   // per bank grants and read registers
   logic [XBAR_PORTS-1:0] bank_grant [NUM_BANKS];
   logic [DATA_W-1:0]     bank_rdata [NUM_BANKS];

   // response tracking for the two core ports
   logic drsp_v_r;
   logic irsp_v_r;
   logic dbank_r;
   logic ibank_r;

   assign d_word = dreq_i.addr[ADDR_WORD_LSB +: MEM_ADDR_W];
   assign i_word = ireq_i.addr[ADDR_WORD_LSB +: MEM_ADDR_W];
   assign n_word = net_pkt_i.addr[MEM_ADDR_W-1:0];

   // dmem port, remote requests go to the network instead
   assign port_v[0]     = dreq_i.v & ~dreq_i.addr[REMOTE_BIT] & ~freeze_i;
   assign port_we[0]    = dreq_i.we;
   assign port_bank[0]  = d_word[0];
   assign port_row[0]   = d_word[MEM_ADDR_W-1:1];
   assign port_wdata[0] = dreq_i.wdata;
   assign port_mask[0]  = dreq_i.mask;

   // network port, only stores touch memory and freeze does not block them
   assign port_v[1]     = net_v_i & (net_pkt_i.op == OP_STORE);
   assign port_we[1]    = 1'b1;
   assign port_bank[1]  = n_word[0];
   assign port_row[1]   = n_word[MEM_ADDR_W-1:1];
   assign port_wdata[1] = net_pkt_i.data;
   assign port_mask[1]  = net_pkt_i.mask;

   // imem port is read only
   assign port_v[2]     = ireq_i.v & ~freeze_i;
   assign port_we[2]    = 1'b0;
   assign port_bank[2]  = i_word[0];
   assign port_row[2]   = i_word[MEM_ADDR_W-1:1];
   assign port_wdata[2] = ireq_i.wdata;
   assign port_mask[2]  = ireq_i.mask;

   for (genvar b = 0; b < NUM_BANKS; b++)
   begin : g_bank
      logic [DATA_W-1:0]     mem [BANK_WORDS];
      logic [XBAR_PORTS-1:0] req;
      logic [PORT_SEL_W-1:0] sel;
      logic [DATA_W-1:0]     merged;
      logic [DATA_W-1:0]     rdata_r;

      // ports addressing this bank
      always_comb
      begin
         for (int p = 0; p < XBAR_PORTS; p++)
            req[p] = port_v[p] & (port_bank[p] == 1'(b));
      end

      // lowest index wins, scanned from the bottom of the priority list
      always_comb
      begin
         sel = '0;
         for (int p = XBAR_PORTS - 1; p >= 0; p--)
            if (req[p])
               sel = PORT_SEL_W'(p);
      end

      always_comb
      begin
         for (int p = 0; p < XBAR_PORTS; p++)
            bank_grant[b][p] = req[p] & (sel == PORT_SEL_W'(p));
      end

      // byte-masked merge of the write data into the stored word
      always_comb
      begin
         merged = mem[port_row[sel]];
         for (int i = 0; i < MASK_W; i++)
            if (port_mask[sel][i])
               merged[8*i +: 8] = port_wdata[sel][8*i +: 8];
      end

      // writes answer with the updated word, reads with the stored one
      always_ff @(posedge clk_i)
      begin
         if (|req)
         begin
            if (port_we[sel])
               mem[port_row[sel]] <= merged;
            rdata_r <= port_we[sel] ? merged : mem[port_row[sel]];
         end
      end

      assign bank_rdata[b] = rdata_r;
   end

   // a port is accepted if any bank granted it
   always_comb
   begin
      port_yumi = '0;
      for (int b = 0; b < NUM_BANKS; b++)
         port_yumi = port_yumi | bank_grant[b];
   end

   assign dyumi_o    = port_yumi[0];
   assign net_yumi_o = port_yumi[1];
   assign iyumi_o    = port_yumi[2];

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         drsp_v_r <= 1'b0;
         irsp_v_r <= 1'b0;
      end
      else
      begin
         drsp_v_r <= port_yumi[0];
         irsp_v_r <= port_yumi[2];
      end
   end

   // remember which bank holds each response
   always_ff @(posedge clk_i)
   begin
      dbank_r <= port_bank[0];
      ibank_r <= port_bank[2];
   end

   assign drsp_o.v    = drsp_v_r;
   assign drsp_o.data = bank_rdata[dbank_r];
   assign irsp_o.v    = irsp_v_r;
   assign irsp_o.data = bank_rdata[ibank_r];

endmodule

//--- design/reserve_tracker.sv
module reserve_tracker import tile_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  mem_req_t              dreq_i,
   input  logic                  dyumi_i,
   input  logic                  net_commit_i,
   input  logic [MEM_ADDR_W-1:0] net_addr_i,
   output logic                  reservation_o
);

   logic                  set;
   logic                  clear;
   logic [MEM_ADDR_W-1:0] addr_r;

   // reserved load accepted by the scratchpad
   assign set   = dreq_i.v & dreq_i.reserve & dyumi_i;
   // a remote store hitting the reserved word breaks it
   assign clear = net_commit_i & (net_addr_i == addr_r);

   always_ff @(posedge clk_i)
   begin
      if (set)
         addr_r <= dreq_i.addr[ADDR_WORD_LSB +: MEM_ADDR_W];
   end

   // a new reservation beats a clear in the same cycle
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         reservation_o <= 1'b0;
      else if (set)
         reservation_o <= 1'b1;
      else if (clear)
         reservation_o <= 1'b0;
   end

endmodule

//--- design/tile_proc.sv
module tile_proc import tile_pkg::*;
(
   input  logic              clk_i,
   input  logic              arst_n_i,
   // core instruction and data ports
   input  mem_req_t          imem_req_i,
   output logic              imem_yumi_o,
   output mem_rsp_t          imem_rsp_o,
   input  mem_req_t          dmem_req_i,
   output logic              dmem_yumi_o,
   output mem_rsp_t          dmem_rsp_o,
   // network input side
   input  net_pkt_t          link_pkt_i,
   input  logic              link_v_i,
   output logic              in_credit_o,
   // network output side
   output net_pkt_t          link_pkt_o,
   output logic              link_v_o,
   input  logic              out_credit_i,
   // tile position and status
   input  logic [CORD_W-1:0] my_x_i,
   input  logic [CORD_W-1:0] my_y_i,
   output logic              freeze_o,
   output logic              reservation_o,
   output logic              outstanding_o
);

   net_pkt_t in_pkt;
   logic     in_v;
   logic     in_yumi;
   logic     mem_net_yumi;
   logic     frz_pop;
   logic     mem_dyumi;
   logic     remote_v;
   logic     has_credit;
   logic     send;

   // head leaves the queue on a store commit or a control packet
   assign in_yumi = mem_net_yumi | frz_pop;

   // remote requests go out only on credit and while running
   assign send     = remote_v & has_credit & ~freeze_o;
   assign link_v_o = send;

   // dmem is dequeued by either the scratchpad or the network
   assign dmem_yumi_o = mem_dyumi | send;

   net_in_fifo u_in_fifo
   (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .v_i      (link_v_i),
      .pkt_i    (link_pkt_i),
      .v_o      (in_v),
      .pkt_o    (in_pkt),
      .yumi_i   (in_yumi),
      .credit_o (in_credit_o)
   );

   out_credit_counter u_out_credit
   (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .send_i          (send),
      .credit_return_i (out_credit_i),
      .has_credit_o    (has_credit),
      .outstanding_o   (outstanding_o)
   );

   pkt_encode u_pkt_encode
   (
      .req_i  (dmem_req_i),
      .my_x_i (my_x_i),
      .my_y_i (my_y_i),
      .v_o    (remote_v),
      .pkt_o  (link_pkt_o)
   );

   banked_xbar_mem u_mem
   (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .freeze_i   (freeze_o),
      .dreq_i     (dmem_req_i),
      .ireq_i     (imem_req_i),
      .net_v_i    (in_v),
      .net_pkt_i  (in_pkt),
      .dyumi_o    (mem_dyumi),
      .iyumi_o    (imem_yumi_o),
      .net_yumi_o (mem_net_yumi),
      .drsp_o     (dmem_rsp_o),
      .irsp_o     (imem_rsp_o)
   );

   freeze_ctrl u_freeze
   (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .net_v_i   (in_v),
      .net_pkt_i (in_pkt),
      .pop_o     (frz_pop),
      .freeze_o  (freeze_o)
   );

   // only local grants can reserve, and only committed stores clear
   reserve_tracker u_reserve
   (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .dreq_i        (dmem_req_i),
      .dyumi_i       (mem_dyumi),
      .net_commit_i  (mem_net_yumi),
      .net_addr_i    (in_pkt.addr[MEM_ADDR_W-1:0]),
      .reservation_o (reservation_o)
   );

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_tile_proc -f all.f -o tb_sim \
   || { echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Regression passed" sim.log || { echo "FAIL: no result in log"; exit 1; }
echo "PASS"

//--- test/tb_clock_gen.sv
module tb_clock_gen
(
   output logic clk_o,
   output logic arst_n_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int HALF_PERIOD  = 10;
   localparam int RESET_CYCLES = 3;

   // free running 20 ns clock
   initial
   begin
      clk_o = 1'b0;
      forever
         #(HALF_PERIOD) clk_o = ~clk_o;
   end

   // reset low over the first rising edges, released just after one
   initial
   begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #2;
      arst_n_o = 1'b1;
   end

endmodule

//--- test/tb_tile_proc.sv
module tb_tile_proc import tile_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int DRIVE_DELAY = 2;
   localparam int NUM_WORDS   = 8;
   localparam int NUM_IN_PKTS = 6;
   // rough cycle budget of each test for the watchdog
   localparam int RESET_LEN   = 20;
   localparam int MEM_LEN     = 200;
   localparam int NET_LEN     = 100;
   localparam int OUT_LEN     = 80;
   localparam int RSV_LEN     = 80;
   localparam int WATCHDOG_NS = (RESET_LEN + MEM_LEN + NET_LEN + OUT_LEN + RSV_LEN) * 40;

   logic              clk;
   logic              arst_n;
   mem_req_t          imem_req;
   mem_req_t          dmem_req;
   logic              imem_yumi;
   logic              dmem_yumi;
   mem_rsp_t          imem_rsp;
   mem_rsp_t          dmem_rsp;
   net_pkt_t          link_pkt_in;
   net_pkt_t          link_pkt_out;
   logic              link_v_in;
   logic              link_v_out;
   logic              in_credit;
   logic              out_credit;
   logic [CORD_W-1:0] my_x;
   logic [CORD_W-1:0] my_y;
   logic              freeze;
   logic              reservation;
   logic              outstanding;

   // core and network model state
   logic [DATA_W-1:0]     shadow [1 << MEM_ADDR_W];
   logic [MEM_ADDR_W-1:0] words [NUM_WORDS];
   int                    net_credits   = IN_FIFO_ELS;
   int                    credit_pulses = 0;
   int                    pkts_sent     = 0;
   // credits the tile still holds for outgoing packets
   int                    out_avail     = MAX_OUT_CREDITS;
   integer                seed          = 80;
   string                 test_name     = "init";

   tb_clock_gen u_clk
   (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   tile_proc dut
   (
      .clk_i         (clk),
      .arst_n_i      (arst_n),
      .imem_req_i    (imem_req),
      .imem_yumi_o   (imem_yumi),
      .imem_rsp_o    (imem_rsp),
      .dmem_req_i    (dmem_req),
      .dmem_yumi_o   (dmem_yumi),
      .dmem_rsp_o    (dmem_rsp),
      .link_pkt_i    (link_pkt_in),
      .link_v_i      (link_v_in),
      .in_credit_o   (in_credit),
      .link_pkt_o    (link_pkt_out),
      .link_v_o      (link_v_out),
      .out_credit_i  (out_credit),
      .my_x_i        (my_x),
      .my_y_i        (my_y),
      .freeze_o      (freeze),
      .reservation_o (reservation),
      .outstanding_o (outstanding)
   );

   task automatic stop_run();
      $display("Regression failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_mismatch(input string what, input logic [63:0] expected,
                                  input logic [63:0] actual);
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      stop_run();
   endtask

   // inputs change a little after the rising edge
   task automatic next_drive();
      @(posedge clk);
      #(DRIVE_DELAY);
   endtask

   // written bytes replace the old ones where the mask is set
   function automatic logic [DATA_W-1:0] apply_mask(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input logic [MASK_W-1:0] mask);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int i = 0; i < MASK_W; i++)
         if (mask[i])
            res[8*i +: 8] = new_w[8*i +: 8];
      return res;
   endfunction

   function automatic logic [31:0] byte_addr(input logic [MEM_ADDR_W-1:0] word);
      return {21'b0, word, 2'b00};
   endfunction

   // packet fields taken straight from the remote address layout
   function automatic net_pkt_t expected_out(input logic [31:0] addr,
                                             input logic [DATA_W-1:0] wdata,
                                             input logic [MASK_W-1:0] mask);
      net_pkt_t p;
      p.op     = OP_STORE;
      p.x_cord = addr[23:22];
      p.y_cord = addr[21:20];
      p.src_x  = my_x;
      p.src_y  = my_y;
      p.addr   = addr[13:2];
      p.data   = wdata;
      p.mask   = mask;
      return p;
   endfunction

   task automatic make_remote_addr(output logic [31:0] addr);
      logic [31:0] rnd;
      rnd  = $random(seed);
      addr = {1'b1, 7'b0, rnd[23:20], 6'b0, rnd[11:0], 2'b00};
   endtask

   // one local dmem access with its response checked one cycle after yumi
   task automatic dmem_access(input logic is_write, input logic is_reserve,
                              input logic [MEM_ADDR_W-1:0] word,
                              input logic [DATA_W-1:0] wdata,
                              input logic [MASK_W-1:0] mask);
      logic [DATA_W-1:0] expected;
      expected = is_write ? apply_mask(shadow[word], wdata, mask) : shadow[word];
      if (is_write)
         shadow[word] = expected;
      dmem_req = '{v: 1'b1, we: is_write, reserve: is_reserve, addr: byte_addr(word),
                   wdata: wdata, mask: mask};
      @(negedge clk);
      while (!dmem_yumi)
      begin
         next_drive();
         @(negedge clk);
      end
      next_drive();
      dmem_req.v = 1'b0;
      @(negedge clk);
      assert (dmem_rsp.v)
         else report_mismatch("dmem rsp valid", 64'(1), 64'(dmem_rsp.v));
      assert (dmem_rsp.data == expected)
         else report_mismatch("dmem rsp data", 64'(expected), 64'(dmem_rsp.data));
      next_drive();
   endtask

   task automatic imem_read(input logic [MEM_ADDR_W-1:0] word);
      imem_req = '{v: 1'b1, we: 1'b0, reserve: 1'b0, addr: byte_addr(word),
                   wdata: '0, mask: '0};
      @(negedge clk);
      while (!imem_yumi)
      begin
         next_drive();
         @(negedge clk);
      end
      next_drive();
      imem_req.v = 1'b0;
      @(negedge clk);
      assert (imem_rsp.v)
         else report_mismatch("imem rsp valid", 64'(1), 64'(imem_rsp.v));
      assert (imem_rsp.data == shadow[word])
         else report_mismatch("imem rsp data", 64'(shadow[word]), 64'(imem_rsp.data));
      next_drive();
   endtask

   // network model sends only while it holds a credit
   task automatic net_send(input net_op_e op, input logic [MEM_ADDR_W-1:0] word,
                           input logic [DATA_W-1:0] data, input logic [MASK_W-1:0] mask);
      while (net_credits == 0)
         next_drive();
      link_pkt_in = '{op: op, x_cord: my_x, y_cord: my_y, src_x: 2'd0, src_y: 2'd0,
                      addr: NET_ADDR_W'(word), data: data, mask: mask};
      link_v_in   = 1'b1;
      net_credits--;
      pkts_sent++;
      if (op == OP_STORE)
         shadow[word] = apply_mask(shadow[word], data, mask);
      next_drive();
      link_v_in = 1'b0;
   endtask

   task automatic wait_drain();
      while (credit_pulses != pkts_sent)
         next_drive();
      // idle a little so a stray extra pulse would show
      repeat (4) next_drive();
      assert (credit_pulses == pkts_sent)
         else report_mismatch("credit pulses", 64'(pkts_sent), 64'(credit_pulses));
   endtask

   // waits for the remote request to leave and checks the packet
   task automatic await_send(input net_pkt_t want);
      @(negedge clk);
      while (!dmem_yumi)
      begin
         next_drive();
         @(negedge clk);
      end
      assert (link_v_out)
         else report_mismatch("link valid", 64'(1), 64'(link_v_out));
      assert (link_pkt_out == want)
         else report_mismatch("link packet", 64'(want), 64'(link_pkt_out));
      next_drive();
      dmem_req.v = 1'b0;
   endtask

   // returned credits counted where outputs are stable
   always @(negedge clk)
   begin
      if (arst_n && in_credit)
      begin
         net_credits++;
         credit_pulses++;
      end
   end

   // each send takes a credit and each out_credit pulse gives one back
   always @(posedge clk)
   begin
      if (arst_n)
         out_avail <= out_avail + int'(out_credit) - int'(link_v_out);
   end

   // a packet goes out only while the tile still holds a credit
   assert property (@(posedge clk) disable iff (!arst_n) link_v_out |-> (out_avail > 0))
      else
      begin
         $display("ERROR %s: packet sent with no outgoing credit left", test_name);
         stop_run();
      end

   assert property (@(posedge clk) disable iff (!arst_n)
                    (dmem_yumi && !link_v_out) |=> dmem_rsp.v)
      else report_mismatch("dmem rsp one cycle after yumi", 64'(1), 64'(dmem_rsp.v));

   assert property (@(posedge clk) disable iff (!arst_n) imem_yumi |=> imem_rsp.v)
      else report_mismatch("imem rsp one cycle after yumi", 64'(1), 64'(imem_rsp.v));

   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
      stop_run();
   end

   initial
   begin
      logic [31:0]       rnd;
      logic [31:0]       raddr;
      logic [MASK_W-1:0] m;
      logic [DATA_W-1:0] new_val;
      imem_req    = '0;
      dmem_req    = '0;
      link_pkt_in = '0;
      link_v_in   = 1'b0;
      out_credit  = 1'b0;
      my_x        = 2'd1;
      my_y        = 2'd2;
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         rnd      = $random(seed);
         words[i] = rnd[MEM_ADDR_W-1:0];
      end

      test_name = "reset";
      @(posedge arst_n);
      @(negedge clk);
      assert (freeze)
         else report_mismatch("freeze", 64'(1), 64'(freeze));
      assert ({link_v_out, in_credit, imem_yumi, dmem_yumi, imem_rsp.v, dmem_rsp.v,
               reservation, outstanding} == 8'h00)
         else report_mismatch("idle outputs", 64'(0), 64'({link_v_out, in_credit,
               imem_yumi, dmem_yumi, imem_rsp.v, dmem_rsp.v, reservation, outstanding}));
      next_drive();
      // frozen tile ignores the core
      dmem_req = '{v: 1'b1, we: 1'b0, reserve: 1'b0, addr: byte_addr(words[0]),
                   wdata: '0, mask: '0};
      repeat (3)
      begin
         @(negedge clk);
         assert (!dmem_yumi)
            else report_mismatch("dmem yumi while frozen", 64'(0), 64'(dmem_yumi));
         next_drive();
      end
      dmem_req.v = 1'b0;

      test_name = "freeze_and_memory";
      net_send(OP_FREEZE, '0, 32'h0, 4'h0);
      for (int n = 0; n < 8 && freeze; n++)
         next_drive();
      assert (!freeze)
         else report_mismatch("freeze", 64'(0), 64'(freeze));
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         rnd = $random(seed);
         dmem_access(1'b1, 1'b0, words[i], rnd, 4'hF);
      end
      // partial writes on top of known words
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         rnd = $random(seed);
         m   = rnd[MASK_W-1:0];
         rnd = $random(seed);
         dmem_access(1'b1, 1'b0, words[i], rnd, m);
      end
      for (int i = 0; i < NUM_WORDS; i++)
         dmem_access(1'b0, 1'b0, words[i], '0, '0);
      for (int i = 0; i < NUM_WORDS; i++)
         imem_read(words[i]);
      // dmem write goes ahead of an imem read of the same word
      new_val  = $random(seed);
      dmem_req = '{v: 1'b1, we: 1'b1, reserve: 1'b0, addr: byte_addr(words[0]),
                   wdata: new_val, mask: 4'hF};
      imem_req = '{v: 1'b1, we: 1'b0, reserve: 1'b0, addr: byte_addr(words[0]),
                   wdata: '0, mask: '0};
      shadow[words[0]] = new_val;
      @(negedge clk);
      assert ({dmem_yumi, imem_yumi} == 2'b10)
         else report_mismatch("bank priority", 64'(2'b10), 64'({dmem_yumi, imem_yumi}));
      next_drive();
      dmem_req.v = 1'b0;
      @(negedge clk);
      assert (imem_yumi)
         else report_mismatch("imem yumi after dmem", 64'(1), 64'(imem_yumi));
      assert (dmem_rsp.data == new_val)
         else report_mismatch("dmem rsp data", 64'(new_val), 64'(dmem_rsp.data));
      next_drive();
      imem_req.v = 1'b0;
      @(negedge clk);
      assert (imem_rsp.data == new_val)
         else report_mismatch("imem rsp data", 64'(new_val), 64'(imem_rsp.data));
      next_drive();

      test_name = "incoming";
      for (int i = 0; i < NUM_IN_PKTS; i++)
      begin
         rnd = $random(seed);
         m   = rnd[MASK_W-1:0];
         rnd = $random(seed);
         net_send(OP_STORE, words[i % NUM_WORDS], rnd, m);
      end
      wait_drain();
      for (int i = 0; i < NUM_WORDS; i++)
         dmem_access(1'b0, 1'b0, words[i], '0, '0);

      test_name = "outgoing";
      for (int i = 0; i < MAX_OUT_CREDITS; i++)
      begin
         make_remote_addr(raddr);
         rnd      = $random(seed);
         dmem_req = '{v: 1'b1, we: 1'b1, reserve: 1'b0, addr: raddr, wdata: rnd, mask: 4'hF};
         await_send(expected_out(raddr, rnd, 4'hF));
      end
      // with no credits left the next request has to wait
      make_remote_addr(raddr);
      rnd      = $random(seed);
      dmem_req = '{v: 1'b1, we: 1'b1, reserve: 1'b0, addr: raddr, wdata: rnd, mask: 4'h5};
      repeat (3)
      begin
         @(negedge clk);
         assert (!link_v_out && !dmem_yumi)
            else report_mismatch("send without credit", 64'(0), 64'({link_v_out, dmem_yumi}));
         assert (outstanding)
            else report_mismatch("outstanding", 64'(1), 64'(outstanding));
         next_drive();
      end
      out_credit = 1'b1;
      next_drive();
      out_credit = 1'b0;
      await_send(expected_out(raddr, rnd, 4'h5));
      // hand back every credit still held by the network
      out_credit = 1'b1;
      repeat (MAX_OUT_CREDITS)
      begin
         @(negedge clk);
         assert (outstanding)
            else report_mismatch("outstanding", 64'(1), 64'(outstanding));
         next_drive();
      end
      out_credit = 1'b0;
      @(negedge clk);
      assert (!outstanding)
         else report_mismatch("outstanding", 64'(0), 64'(outstanding));
      next_drive();

      test_name = "reservation";
      dmem_access(1'b0, 1'b1, words[2], '0, '0);
      assert (reservation)
         else report_mismatch("reservation set", 64'(1), 64'(reservation));
      rnd = $random(seed);
      net_send(OP_STORE, words[2] ^ 9'h002, rnd, 4'hF);
      wait_drain();
      assert (reservation)
         else report_mismatch("reservation kept", 64'(1), 64'(reservation));
      rnd = $random(seed);
      net_send(OP_STORE, words[2], rnd, 4'hF);
      wait_drain();
      assert (!reservation)
         else report_mismatch("reservation cleared", 64'(0), 64'(reservation));
      dmem_access(1'b0, 1'b0, words[2], '0, '0);

      $display("Regression passed");
      $finish;
   end

endmodule
